// File: logic/egr_wadj_pkg.sv
// shared egress width adjuster types; port and multicast widths are fixed here, not per instance
`default_nettype none

package egr_wadj_pkg;

   // -------------------------------------------------------------------
   // field widths
   // -------------------------------------------------------------------
   localparam int PORT_WIDTH  = 4;
   localparam int MCAST_WIDTH = 16;

   // -------------------------------------------------------------------
   // per-beat side information, 27 bits
   // -------------------------------------------------------------------
   typedef struct packed {
      logic                   sop;
      logic                   eop;
      logic [PORT_WIDTH-1:0]  igr_port;
      logic [PORT_WIDTH-1:0]  egr_port;
      logic [MCAST_WIDTH-1:0] multicast_port;
      logic                   multicast_en;
   } seg_info_t;

   // -------------------------------------------------------------------
   // serializer FSM
   // -------------------------------------------------------------------
   // empty: nothing held, send: held beat still has segments to emit
   typedef enum logic {
      SER_EMPTY = 1'b0,
      SER_SEND  = 1'b1
   } ser_state_t;

endpackage

`default_nettype wire

// File: logic/wide_beat_if.sv
// one decoded ingress beat; EGR_DATA_WIDTH must divide IGR_DATA_WIDTH, both multiples of 8
`timescale 1ns/1ps
`default_nettype none

interface wide_beat_if #(
   parameter int IGR_DATA_WIDTH = 512,
   parameter int EGR_DATA_WIDTH = 128
) ();
   import egr_wadj_pkg::*;

   localparam int SEG_CNT = IGR_DATA_WIDTH / EGR_DATA_WIDTH;

   logic                        valid;
   logic                        ready;
   logic [IGR_DATA_WIDTH-1:0]   data;
   logic [IGR_DATA_WIDTH/8-1:0] keep;
   // one bit per egress segment
   logic [SEG_CNT-1:0]          seg_nonempty;
   logic [SEG_CNT-1:0]          seg_last;
   seg_info_t                   info;

   modport source (output valid, data, keep, seg_nonempty, seg_last, info,
                   input  ready);

   modport sink   (input  valid, data, keep, seg_nonempty, seg_last, info,
                   output ready);

endinterface

`default_nettype wire

// File: logic/narrow_beat_if.sv
// one egress segment with its side info; source holds payload stable until ready
`timescale 1ns/1ps
`default_nettype none

interface narrow_beat_if #(
   parameter int EGR_DATA_WIDTH = 128
) ();
   import egr_wadj_pkg::*;

   logic                        valid;
   logic                        ready;
   logic [EGR_DATA_WIDTH-1:0]   data;
   logic [EGR_DATA_WIDTH/8-1:0] keep;
   // set on the final non-empty segment of an eop beat
   logic                        last;
   seg_info_t                   info;

   // serializer side
   modport source (output valid, data, keep, last, info,
                   input  ready);

   // framing side
   modport sink   (input  valid, data, keep, last, info,
                   output ready);

endinterface

`default_nettype wire

// File: logic/egr_seg_decode.sv
// combinational, zero latency; an eop beat with no keep bits set produces no tlast
`timescale 1ns/1ps
`default_nettype none

module egr_seg_decode #(
   parameter int IGR_DATA_WIDTH = 512,
   parameter int EGR_DATA_WIDTH = 128,
   parameter int BYTE_ROTATE    = 1
) (
   input  var logic                        s_tvalid_i,
   input  var logic [IGR_DATA_WIDTH-1:0]   s_tdata_i,
   input  var logic [IGR_DATA_WIDTH/8-1:0] s_tkeep_i,
   input  var egr_wadj_pkg::seg_info_t     s_info_i,
   output var logic                        s_tready_o,
   wide_beat_if.source                     beat_o
);

   localparam int IGR_KEEP_W = IGR_DATA_WIDTH / 8;
   localparam int SEG_CNT    = IGR_DATA_WIDTH / EGR_DATA_WIDTH;
   localparam int SEG_KEEP_W = IGR_KEEP_W / SEG_CNT;

   logic [IGR_DATA_WIDTH-1:0] data_rot;
   logic [IGR_KEEP_W-1:0]     keep_rot;
   logic [SEG_CNT-1:0]        seg_nonempty;
   logic [SEG_CNT-1:0]        seg_last;

   // -------------------------------------------------------------------
   // byte order, data and keep move together
   // -------------------------------------------------------------------
   always_comb begin
      for (int k = 0; k < IGR_KEEP_W; k++) begin
         if (BYTE_ROTATE != 0) begin
            // msb byte lands in lane 0
            data_rot[8*(IGR_KEEP_W-1-k) +: 8] = s_tdata_i[8*k +: 8];
            keep_rot[IGR_KEEP_W-1-k]          = s_tkeep_i[k];
         end else begin
            data_rot[8*k +: 8] = s_tdata_i[8*k +: 8];
            keep_rot[k]        = s_tkeep_i[k];
         end
      end
   end

   // -------------------------------------------------------------------
   // segment occupancy and last marker
   // -------------------------------------------------------------------
   always_comb begin
      seg_last = '0;
      for (int i = 0; i < SEG_CNT; i++) begin
         seg_nonempty[i] = |keep_rot[i*SEG_KEEP_W +: SEG_KEEP_W];
         // highest non-empty segment wins
         if (seg_nonempty[i]) begin
            seg_last    = '0;
            seg_last[i] = s_info_i.eop;
         end
      end
   end

   assign beat_o.valid        = s_tvalid_i;
   assign beat_o.data         = data_rot;
   assign beat_o.keep         = keep_rot;
   assign beat_o.seg_nonempty = seg_nonempty;
   assign beat_o.seg_last     = seg_last;
   assign beat_o.info         = s_info_i;

   // serializer decides when the wide beat can move
   assign s_tready_o = beat_o.ready;

endmodule

`default_nettype wire

// File: logic/egr_seg_serialize.sv
// holds one wide beat; first segment one cycle after acceptance, empty segments cost nothing
`timescale 1ns/1ps
`default_nettype none

module egr_seg_serialize #(
   parameter int IGR_DATA_WIDTH = 512,
   parameter int EGR_DATA_WIDTH = 128
) (
   input var logic       clk,
   input var logic       rst_reg_posedge,
   wide_beat_if.sink     beat_i,
   narrow_beat_if.source seg_o
);
   import egr_wadj_pkg::*;

   localparam int SEG_CNT    = IGR_DATA_WIDTH / EGR_DATA_WIDTH;
   localparam int IGR_KEEP_W = IGR_DATA_WIDTH / 8;
   localparam int EGR_KEEP_W = EGR_DATA_WIDTH / 8;
   localparam int IDX_W      = (SEG_CNT > 1) ? $clog2(SEG_CNT) : 1;

   ser_state_t                state;
   // segments of the held beat not yet sent
   logic [SEG_CNT-1:0]        pend_q;
   logic [IGR_DATA_WIDTH-1:0] data_q;
   logic [IGR_KEEP_W-1:0]     keep_q;
   logic [SEG_CNT-1:0]        last_q;
   seg_info_t                 info_q;

   logic [IDX_W-1:0]          cur_idx;
   logic [SEG_CNT-1:0]        pend_after;
   logic                      final_seg;
   logic                      seg_done;
   logic                      beat_take;

   // -------------------------------------------------------------------
   // current segment select
   // -------------------------------------------------------------------
   always_comb begin
      cur_idx = '0;
      // lowest pending bit, scan from the top
      for (int i = SEG_CNT - 1; i >= 0; i--) begin
         if (pend_q[i]) begin
            cur_idx = IDX_W'(i);
         end
      end
   end

   assign pend_after = pend_q & ~(SEG_CNT'(1) << cur_idx);
   assign final_seg  = (pend_after == '0);

   assign seg_done  = seg_o.valid && seg_o.ready;
   assign beat_take = beat_i.valid && beat_i.ready;

   // free slot, or the held beat leaves on this edge
   assign beat_i.ready = (state == SER_EMPTY) || (seg_done && final_seg);

   // -------------------------------------------------------------------
   // FSM and pending mask
   // -------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst_reg_posedge) begin
         state  <= SER_EMPTY;
         pend_q <= '0;
      end else if (beat_take) begin
         pend_q <= beat_i.seg_nonempty;
         // an all-empty beat is swallowed here
         state  <= (|beat_i.seg_nonempty) ? SER_SEND : SER_EMPTY;
      end else if (seg_done) begin
         pend_q <= pend_after;
         if (final_seg) begin
            state <= SER_EMPTY;
         end
      end
   end

   // held beat payload
   always_ff @(posedge clk) begin
      if (beat_take) begin
         data_q <= beat_i.data;
         keep_q <= beat_i.keep;
         last_q <= beat_i.seg_last;
         info_q <= beat_i.info;
      end
   end

   // -------------------------------------------------------------------
   // egress segment
   // -------------------------------------------------------------------
   assign seg_o.valid = (state == SER_SEND);
   assign seg_o.data  = data_q[cur_idx*EGR_DATA_WIDTH +: EGR_DATA_WIDTH];
   assign seg_o.keep  = keep_q[cur_idx*EGR_KEEP_W +: EGR_KEEP_W];
   assign seg_o.last  = last_q[cur_idx];
   assign seg_o.info  = info_q;

endmodule

`default_nettype wire

// File: logic/egr_frame_result.sv
// sop is regenerated from tlast history, so the ingress sop field is ignored
`timescale 1ns/1ps
`default_nettype none

module egr_frame_result #(
   parameter int EGR_DATA_WIDTH = 128
) (
   input  var logic                        clk,
   input  var logic                        rst_reg_posedge,
   narrow_beat_if.sink                     seg_i,
   input  var logic                        m_tready_i,
   output var logic                        m_tvalid_o,
   output var logic [EGR_DATA_WIDTH-1:0]   m_tdata_o,
   output var logic [EGR_DATA_WIDTH/8-1:0] m_tkeep_o,
   output var logic                        m_tlast_o,
   output var egr_wadj_pkg::seg_info_t     m_info_o
);
   import egr_wadj_pkg::*;

   logic                   sop_state;
   logic                   seg_xfer;
   // multicast fields of the packet's first segment
   logic [MCAST_WIDTH-1:0] mcast_port_q;
   logic                   mcast_en_q;

   assign seg_i.ready = m_tready_i;
   assign seg_xfer    = seg_i.valid && m_tready_i;

   // -------------------------------------------------------------------
   // packet start tracking
   // -------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst_reg_posedge) begin
         sop_state <= 1'b1;
      end else if (seg_xfer) begin
         // next segment opens a packet only after a tlast
         sop_state <= seg_i.last;
      end
   end

   always_ff @(posedge clk) begin
      if (seg_xfer && sop_state) begin
         mcast_port_q <= seg_i.info.multicast_port;
         mcast_en_q   <= seg_i.info.multicast_en;
      end
   end

   // -------------------------------------------------------------------
   // egress beat
   // -------------------------------------------------------------------
   assign m_tvalid_o = seg_i.valid;
   assign m_tdata_o  = seg_i.data;
   assign m_tkeep_o  = seg_i.keep;
   assign m_tlast_o  = seg_i.last;

   always_comb begin
      m_info_o.sop      = sop_state;
      m_info_o.eop      = seg_i.last;
      m_info_o.igr_port = seg_i.info.igr_port;
      m_info_o.egr_port = seg_i.info.egr_port;
      // later wide beats may carry stale multicast values
      m_info_o.multicast_port = sop_state ? seg_i.info.multicast_port : mcast_port_q;
      m_info_o.multicast_en   = sop_state ? seg_i.info.multicast_en : mcast_en_q;
   end

endmodule

`default_nettype wire

// File: logic/egr_wadj_top.sv
// 1 cycle ingress to egress latency; EGR_DATA_WIDTH must divide IGR_DATA_WIDTH
`timescale 1ns/1ps
`default_nettype none

module egr_wadj_top #(
   parameter int IGR_DATA_WIDTH = 512,
   parameter int EGR_DATA_WIDTH = 128,
   parameter int BYTE_ROTATE    = 1
) (
   input  var logic                                 clk,
   input  var logic                                 rst_reg_posedge,
   // ingress
   input  var logic                                 s_tvalid_i,
   input  var logic [IGR_DATA_WIDTH-1:0]            s_tdata_i,
   input  var logic [IGR_DATA_WIDTH/8-1:0]          s_tkeep_i,
   input  var logic                                 s_eop_i,
   input  var logic [egr_wadj_pkg::PORT_WIDTH-1:0]  s_igr_port_i,
   input  var logic [egr_wadj_pkg::PORT_WIDTH-1:0]  s_egr_port_i,
   input  var logic [egr_wadj_pkg::MCAST_WIDTH-1:0] s_mcast_port_i,
   input  var logic                                 s_mcast_en_i,
   output var logic                                 s_tready_o,
   // egress
   output var logic                                 m_tvalid_o,
   output var logic [EGR_DATA_WIDTH-1:0]            m_tdata_o,
   output var logic [EGR_DATA_WIDTH/8-1:0]          m_tkeep_o,
   output var logic                                 m_tlast_o,
   output var logic                                 m_sop_o,
   output var logic [egr_wadj_pkg::PORT_WIDTH-1:0]  m_igr_port_o,
   output var logic [egr_wadj_pkg::PORT_WIDTH-1:0]  m_egr_port_o,
   output var logic [egr_wadj_pkg::MCAST_WIDTH-1:0] m_mcast_port_o,
   output var logic                                 m_mcast_en_o,
   input  var logic                                 m_tready_i
);
   import egr_wadj_pkg::*;

   seg_info_t s_info;
   seg_info_t m_info;

   wide_beat_if #(
      .IGR_DATA_WIDTH (IGR_DATA_WIDTH),
      .EGR_DATA_WIDTH (EGR_DATA_WIDTH)
   ) wide_beat ();

   narrow_beat_if #(
      .EGR_DATA_WIDTH (EGR_DATA_WIDTH)
   ) narrow_beat ();

   // -------------------------------------------------------------------
   // side info packing
   // -------------------------------------------------------------------
   always_comb begin
      // egress sop comes from the framing stage
      s_info.sop            = 1'b0;
      s_info.eop            = s_eop_i;
      s_info.igr_port       = s_igr_port_i;
      s_info.egr_port       = s_egr_port_i;
      s_info.multicast_port = s_mcast_port_i;
      s_info.multicast_en   = s_mcast_en_i;
   end

   assign m_sop_o        = m_info.sop;
   assign m_igr_port_o   = m_info.igr_port;
   assign m_egr_port_o   = m_info.egr_port;
   assign m_mcast_port_o = m_info.multicast_port;
   assign m_mcast_en_o   = m_info.multicast_en;

   // -------------------------------------------------------------------
   // decode, serialize, framing
   // -------------------------------------------------------------------
   egr_seg_decode #(
      .IGR_DATA_WIDTH (IGR_DATA_WIDTH),
      .EGR_DATA_WIDTH (EGR_DATA_WIDTH),
      .BYTE_ROTATE    (BYTE_ROTATE)
   ) egr_seg_decode_inst (
      .s_tvalid_i (s_tvalid_i),
      .s_tdata_i  (s_tdata_i),
      .s_tkeep_i  (s_tkeep_i),
      .s_info_i   (s_info),
      .s_tready_o (s_tready_o),
      .beat_o     (wide_beat.source)
   );

   egr_seg_serialize #(
      .IGR_DATA_WIDTH (IGR_DATA_WIDTH),
      .EGR_DATA_WIDTH (EGR_DATA_WIDTH)
   ) egr_seg_serialize_inst (
      .clk             (clk),
      .rst_reg_posedge (rst_reg_posedge),
      .beat_i          (wide_beat.sink),
      .seg_o           (narrow_beat.source)
   );

   egr_frame_result #(
      .EGR_DATA_WIDTH (EGR_DATA_WIDTH)
   ) egr_frame_result_inst (
      .clk             (clk),
      .rst_reg_posedge (rst_reg_posedge),
      .seg_i           (narrow_beat.sink),
      .m_tready_i      (m_tready_i),
      .m_tvalid_o      (m_tvalid_o),
      .m_tdata_o       (m_tdata_o),
      .m_tkeep_o       (m_tkeep_o),
      .m_tlast_o       (m_tlast_o),
      .m_info_o        (m_info)
   );

endmodule

`default_nettype wire

// File: tb/tb_egr_wadj_model.svh
// included inside tb_egr_wadj; the model assumes 512-bit ingress, 128-bit egress, rotation on
`ifndef TB_EGR_WADJ_MODEL_SVH
`define TB_EGR_WADJ_MODEL_SVH

// -----------------------------------------------------------------------
// stimulus table
// -----------------------------------------------------------------------
// beats, final byte count, ports, first mcast, junk mcast, bp, b2b
typedef struct {
   int          beats;
   int          last_bytes;
   logic [3:0]  igr;
   logic [3:0]  egr;
   logic [15:0] mport;
   logic        men;
   logic [15:0] jport;
   logic        jen;
   logic        bp;
   logic        b2b;
} pkt_t;

typedef struct {
   logic [127:0] data;
   logic [15:0]  keep;
   logic         last;
   logic         sop;
   logic [3:0]   igr;
   logic [3:0]   egr;
   logic [15:0]  mport;
   logic         men;
   int           pkt;
} exp_beat_t;

localparam int NPKT = 7;

pkt_t      tbl [NPKT];
string     tbl_name [NPKT];
exp_beat_t exp_q [$];
logic      model_sop = 1'b1;

task automatic load_table();
   tbl[0] = '{2, 64, 4'h3, 4'h9, 16'ha5a5, 1'b1, 16'h1111, 1'b0, 1'b0, 1'b0};
   tbl[1] = '{1, 10, 4'h1, 4'h2, 16'h0f0f, 1'b1, 16'h2222, 1'b0, 1'b0, 1'b0};
   tbl[2] = '{3, 37, 4'h7, 4'h4, 16'h8001, 1'b0, 16'hffff, 1'b1, 1'b0, 1'b0};
   tbl[3] = '{2, 64, 4'hc, 4'h5, 16'h1234, 1'b1, 16'h4321, 1'b0, 1'b1, 1'b0};
   tbl[4] = '{3, 50, 4'h2, 4'he, 16'h00ff, 1'b1, 16'hff00, 1'b0, 1'b1, 1'b1};
   tbl[5] = '{1, 64, 4'h8, 4'h8, 16'hbeef, 1'b0, 16'h3333, 1'b1, 1'b0, 1'b1};
   tbl[6] = '{2, 17, 4'hf, 4'h0, 16'hcafe, 1'b1, 16'h5555, 1'b0, 1'b0, 1'b1};
   tbl_name = '{"full beats", "single segment", "partial eop", "back-pressure",
                "back-pressure b2b", "b2b one beat", "b2b partial"};
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

// -----------------------------------------------------------------------
// reference model, one wide beat into expected egress beats
// -----------------------------------------------------------------------
task automatic model_beat(input int p, input logic [511:0] d, input logic [63:0] k,
                          input logic eop);
   logic [511:0] rd;
   logic [63:0]  rk;
   int           hi;
   exp_beat_t    e;
   // ingress byte k goes to byte 63-k
   for (int b = 0; b < 64; b++) begin
      rd[8*(63-b) +: 8] = d[8*b +: 8];
      rk[63-b]          = k[b];
   end
   hi = -1;
   for (int s = 0; s < 4; s++) begin
      if (rk[16*s +: 16] != 16'h0) hi = s;
   end
   for (int s = 0; s < 4; s++) begin
      if (rk[16*s +: 16] != 16'h0) begin
         e.data  = rd[128*s +: 128];
         e.keep  = rk[16*s +: 16];
         e.last  = eop && (s == hi);
         e.sop   = model_sop;
         e.igr   = tbl[p].igr;
         e.egr   = tbl[p].egr;
         e.mport = tbl[p].mport;
         e.men   = tbl[p].men;
         e.pkt   = p;
         exp_q.push_back(e);
         model_sop = e.last;
      end
   end
endtask

`endif

// File: tb/tb_egr_wadj.sv
// drives the default 512 to 128 configuration; stimulus table lives in the model header
`timescale 1ns/1ps
`default_nettype none

module tb_egr_wadj;

   `include "tb_egr_wadj_model.svh"

   localparam int TIMEOUT = 2000;

   logic         clk = 1'b0;
   logic         rst_reg_posedge;
   logic         s_tvalid_i;
   logic [511:0] s_tdata_i;
   logic [63:0]  s_tkeep_i;
   logic         s_eop_i;
   logic [3:0]   s_igr_port_i;
   logic [3:0]   s_egr_port_i;
   logic [15:0]  s_mcast_port_i;
   logic         s_mcast_en_i;
   logic         s_tready_o;
   logic         m_tvalid_o;
   logic [127:0] m_tdata_o;
   logic [15:0]  m_tkeep_o;
   logic         m_tlast_o;
   logic         m_sop_o;
   logic [3:0]   m_igr_port_o;
   logic [3:0]   m_egr_port_o;
   logic [15:0]  m_mcast_port_o;
   logic         m_mcast_en_o;
   logic         m_tready_i;

   int           cyc = 0;
   int           first_xfer_cyc = -1;
   int           pop_cnt = 0;
   int           checks = 0;
   int           errors = 0;
   int           tests = 0;
   int           pkt_err [NPKT];
   logic         bp_on = 1'b0;
   logic [31:0]  data_rnd = 32'h6f2a;
   logic [31:0]  rdy_rnd = 32'h6f2a;
   // snapshot for the back-pressure hold check
   logic         hold_pend = 1'b0;
   logic [127:0] hold_data;
   logic [15:0]  hold_keep;
   logic         hold_last;
   logic         hold_sop;
   logic [15:0]  hold_mport;

   egr_wadj_top egr_wadj_top_inst (.*);

   always #4 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   // egress ready pattern
   always @(posedge clk) begin
      #1;
      m_tready_i = bp_on ? rdy_rnd[0] : 1'b1;
      rdy_rnd    = xorshift32(rdy_rnd);
   end

   // -----------------------------------------------------------------------
   // monitor, sampled mid-cycle
   // -----------------------------------------------------------------------
   always @(negedge clk) begin
      exp_beat_t e;
      if (!rst_reg_posedge) begin
         if (hold_pend) begin
            checks++;
            assert (m_tvalid_o && m_tdata_o == hold_data && m_tkeep_o == hold_keep &&
                    m_tlast_o == hold_last && m_sop_o == hold_sop &&
                    m_mcast_port_o == hold_mport)
            else begin
               $display("Fail %0t: egress changed while stalled", $time);
               errors++;
            end
         end
         hold_pend  = m_tvalid_o && !m_tready_i;
         hold_data  = m_tdata_o;
         hold_keep  = m_tkeep_o;
         hold_last  = m_tlast_o;
         hold_sop   = m_sop_o;
         hold_mport = m_mcast_port_o;
         if (m_tvalid_o && m_tready_i) begin
            checks++;
            assert (exp_q.size() != 0)
            else begin
               $display("Fail %0t: egress beat arrived with nothing expected", $time);
               errors++;
            end
            if (exp_q.size() != 0) begin
               e = exp_q.pop_front();
               checks++;
               assert (m_tdata_o == e.data && m_tkeep_o == e.keep && m_tlast_o == e.last &&
                       m_sop_o == e.sop && m_igr_port_o == e.igr && m_egr_port_o == e.egr &&
                       m_mcast_port_o == e.mport && m_mcast_en_o == e.men)
               else begin
                  $display("Fail %0t: packet %0d beat mismatch keep %h/%h last %b/%b sop %b/%b",
                           $time, e.pkt, m_tkeep_o, e.keep, m_tlast_o, e.last, m_sop_o, e.sop);
                  errors++;
                  pkt_err[e.pkt]++;
               end
               if (pop_cnt == 0) begin
                  checks++;
                  assert (cyc == first_xfer_cyc + 1)
                  else begin
                     $display("Fail %0t: first egress latency %0d cycles", $time,
                              cyc - first_xfer_cyc);
                     errors++;
                     pkt_err[0]++;
                  end
               end
               pop_cnt++;
            end
         end
      end
   end

   task automatic abort_on_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Checks failed");
      $finish;
   endtask

   // holds the current ingress beat until it is accepted
   task automatic wait_accept();
      int n;
      n = 0;
      while (1) begin
         @(negedge clk);
         if (s_tready_o) begin
            if (first_xfer_cyc < 0) first_xfer_cyc = cyc;
            @(posedge clk);
            #1;
            return;
         end
         n++;
         if (n > TIMEOUT) abort_on_timeout("s_tready_o");
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 || m_tvalid_o) begin
         @(posedge clk);
         #1;
         n++;
         if (n > TIMEOUT) abort_on_timeout("egress drain");
      end
   endtask

   task automatic drive_packet(input int p);
      logic [511:0] d;
      logic [63:0]  k;
      logic         eop;
      for (int b = 0; b < tbl[p].beats; b++) begin
         for (int w = 0; w < 16; w++) begin
            d[32*w +: 32] = data_rnd;
            data_rnd      = xorshift32(data_rnd);
         end
         eop = (b == tbl[p].beats - 1);
         k   = eop ? ({64{1'b1}} << (64 - tbl[p].last_bytes)) : {64{1'b1}};
         model_beat(p, d, k, eop);
         s_tvalid_i     = 1'b1;
         s_tdata_i      = d;
         s_tkeep_i      = k;
         s_eop_i        = eop;
         s_igr_port_i   = tbl[p].igr;
         s_egr_port_i   = tbl[p].egr;
         s_mcast_port_i = (b == 0) ? tbl[p].mport : tbl[p].jport;
         s_mcast_en_i   = (b == 0) ? tbl[p].men : tbl[p].jen;
         wait_accept();
      end
   endtask

   // -----------------------------------------------------------------------
   // main sequence
   // -----------------------------------------------------------------------
   initial begin
      int done_upto;
      rst_reg_posedge = 1'b1;
      s_tvalid_i      = 1'b0;
      s_tdata_i       = '0;
      s_tkeep_i       = '0;
      s_eop_i         = 1'b0;
      s_igr_port_i    = '0;
      s_egr_port_i    = '0;
      s_mcast_port_i  = '0;
      s_mcast_en_i    = 1'b0;
      m_tready_i      = 1'b1;
      load_table();
      foreach (pkt_err[i]) pkt_err[i] = 0;
      repeat (8) @(posedge clk);
      #1;
      rst_reg_posedge = 1'b0;

      @(negedge clk);
      checks++;
      tests++;
      assert (!m_tvalid_o && s_tready_o)
      else begin
         $display("Fail %0t: state after reset tvalid %b tready %b", $time,
                  m_tvalid_o, s_tready_o);
         errors++;
      end
      $display("test reset: %s", (errors == 0) ? "ok" : "FAILED");
      @(posedge clk);
      #1;

      done_upto = 0;
      for (int p = 0; p < NPKT; p++) begin
         bp_on = tbl[p].bp;
         drive_packet(p);
         if (p == NPKT - 1 || !tbl[p+1].b2b) begin
            s_tvalid_i = 1'b0;
            wait_drain();
            for (int q = done_upto; q <= p; q++) begin
               tests++;
               $display("test %0d %s: %s", q, tbl_name[q], (pkt_err[q] == 0) ? "ok" : "FAILED");
            end
            done_upto = p + 1;
         end
      end

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: egr_wadj.f
+incdir+tb
logic/egr_wadj_pkg.sv
logic/wide_beat_if.sv
logic/narrow_beat_if.sv
logic/egr_seg_decode.sv
logic/egr_seg_serialize.sv
logic/egr_frame_result.sv
logic/egr_wadj_top.sv
tb/tb_egr_wadj.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_egr_wadj
FILELIST  ?= egr_wadj.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

SRCS := $(wildcard logic/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh) $(FILELIST)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

$(LOG): $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true

run: $(LOG)
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
